// ==== common/arb_pkg.sv ====
/*
  shared widths and scan codes for the round-robin arbiter
  req_vec_t and req_idx_t match the default requester count only;
  modules sized by num_req_p build their own port widths from it
*/
package arb_pkg;

   // default requester count, used as the top-level num_req_p default
   localparam int num_req_c = 8;

   // index width for the default count
   // needs num_req_c of at least 2
   localparam int req_idx_w_c = $clog2(num_req_c);

   // one bit per requester
   // used for requests, priority masks and grants
   typedef logic [num_req_c-1:0] req_vec_t;

   // binary requester number, as reported on grant_id
   typedef logic [req_idx_w_c-1:0] req_idx_t;

   // operation code for prefix_scan
   typedef logic [1:0] scan_op_t;

   // running OR: thermometer from the first set bit onward
   localparam scan_op_t scan_or = 2'd0;

   // running AND: stays high until the first clear bit
   localparam scan_op_t scan_and = 2'd1;

   // running XOR: parity of all bits seen so far
   localparam scan_op_t scan_xor = 2'd2;

   // 2'd3 is not assigned
   // prefix_scan treats it like scan_or

endpackage

// ==== logic/prefix_scan.sv ====
/*
  log-depth prefix scan over num_req_p bits, AND, OR or XOR
  default scans from the high bit down, so the top bit passes unchanged
  lo_to_hi_p mirrors the scan, so the bottom bit passes unchanged
  op codes other than scan_and and scan_xor scan as OR
*/
`timescale 1ns/10ps

module prefix_scan
   import arb_pkg::*;
#(
   parameter int       num_req_p  = num_req_c,
   parameter scan_op_t op_p       = scan_or,
   parameter bit       lo_to_hi_p = 1'b0
)
(
   input  logic [num_req_p-1:0] in,
   output logic [num_req_p-1:0] out
);

   // number of shift-and-combine rows
   // 1 bit needs none, 2 need one, 3..4 need two, 5..8 need three
   localparam int levels_lp = (num_req_p > 1) ? $clog2(num_req_p) : 0;

   // bits shifted in at the top must not disturb the result
   // ones for AND, zeros for OR and XOR
   localparam logic [num_req_p-1:0] fill_lp = (op_p == scan_and) ? '1 : '0;

   // scan core input and result, always in high-to-low order
   logic [num_req_p-1:0] fwd_in;
   logic [num_req_p-1:0] fwd_out;

   // mirror the input for low-to-high scans
   if (lo_to_hi_p)
   begin : g_rev_in
      for (genvar k = 0; k < num_req_p; k++)
      begin : g_bit
         assign fwd_in[k] = in[num_req_p-1-k];
      end
   end
   else
   begin : g_fwd_in
      assign fwd_in = in;
   end

   // short AND scans written out flat
   // these are cheaper than the row structure below
   if ((num_req_p == 4) && (op_p == scan_and))
   begin : g_and4
      assign fwd_out = {fwd_in[3], &fwd_in[3:2], &fwd_in[3:1], &fwd_in[3:0]};
   end
   else if ((num_req_p == 3) && (op_p == scan_and))
   begin : g_and3
      assign fwd_out = {fwd_in[2], &fwd_in[2:1], &fwd_in[2:0]};
   end
   else if ((num_req_p == 2) && (op_p == scan_and))
   begin : g_and2
      assign fwd_out = {fwd_in[1], &fwd_in[1:0]};
   end
   else
   begin : g_scan_n
      // stage[j] holds the op over windows of 2**j bits
      logic [levels_lp:0][num_req_p-1:0] stage;

      assign stage[0] = fwd_in;

      for (genvar j = 0; j < levels_lp; j++)
      begin : g_row
         // partner bits sit 2**j positions higher
         logic [num_req_p-1:0] shifted;

         // shift down, refill the vacated top bits with the identity
         assign shifted = (stage[j] >> (1 << j))
                        | (fill_lp << (num_req_p - (1 << j)));

         if (op_p == scan_and)
         begin : g_and
            assign stage[j+1] = stage[j] & shifted;
         end
         else if (op_p == scan_xor)
         begin : g_xor
            assign stage[j+1] = stage[j] ^ shifted;
         end
         else
         begin : g_or
            assign stage[j+1] = stage[j] | shifted;
         end
      end

      // last row covers every bit from the top down
      assign fwd_out = stage[levels_lp];
   end

   // mirror back so out[k] covers in[k:0] for low-to-high scans
   if (lo_to_hi_p)
   begin : g_rev_out
      for (genvar k = 0; k < num_req_p; k++)
      begin : g_bit
         assign out[k] = fwd_out[num_req_p-1-k];
      end
   end
   else
   begin : g_fwd_out
      assign out = fwd_out;
   end

   // worked example, OR scan, low to high, 8 bits
   //   in          0010_1000
   //   out         1111_1000
   // the lowest set bit and everything above it read as one
   // rr_select turns that back into a one-hot grant

   // worked example, AND scan, high to low, 8 bits
   //   in          1110_1111
   //   out         1110_0000
   // bits stay high only while every bit above them is high

   // worked example, XOR scan, high to low, 8 bits
   //   in          1111_1111
   //   out         1010_1010
   // each bit holds the parity of itself and all bits above it

endmodule

// ==== arbiter/rr_select.sv ====
/*
  combinational winner selection for the round-robin arbiter
  winner is the lowest set request under prio_mask, else the lowest set request
  needs num_req_p of at least 2; all outputs are zero with no requests
*/
`timescale 1ns/10ps

module rr_select
   import arb_pkg::*;
#(
   parameter int num_req_p = num_req_c
)
(
   input  logic [num_req_p-1:0]         req,
   input  logic [num_req_p-1:0]         prio_mask,
   output logic [num_req_p-1:0]         grant,
   output logic                         grant_valid,
   output logic [$clog2(num_req_p)-1:0] grant_id
);

   localparam int idx_w_lp = $clog2(num_req_p);

   // requests at or after the pointer position
   logic [num_req_p-1:0] masked_req;

   // thermometer codes, high from the lowest set bit upward
   logic [num_req_p-1:0] masked_therm;
   logic [num_req_p-1:0] raw_therm;
   logic [num_req_p-1:0] sel_therm;

   assign masked_req = req & prio_mask;

   // scan of the requests that still have priority this round
   prefix_scan #(
      .num_req_p  (num_req_p),
      .op_p       (scan_or),
      .lo_to_hi_p (1'b1)
   ) u_masked_scan (
      .in  (masked_req),
      .out (masked_therm)
   );

   // scan of all requests
   // used when nothing is left above the pointer, which is the wrap case
   prefix_scan #(
      .num_req_p  (num_req_p),
      .op_p       (scan_or),
      .lo_to_hi_p (1'b1)
   ) u_raw_scan (
      .in  (req),
      .out (raw_therm)
   );

   // masked requests win over the wrapped search
   assign sel_therm = (|masked_req) ? masked_therm : raw_therm;

   // edge of the thermometer is the only bit that differs from its
   // lower neighbour, so this leaves just the lowest active bit
   assign grant = sel_therm ^ {sel_therm[num_req_p-2:0], 1'b0};

   // any request at all gives a winner
   assign grant_valid = |req;

   // one-hot to binary as an OR tree per index bit
   // index bit b is the OR of every grant bit whose position has bit b set
   for (genvar b = 0; b < idx_w_lp; b++)
   begin : g_enc
      logic [num_req_p-1:0] pick;

      for (genvar i = 0; i < num_req_p; i++)
      begin : g_pos
         if (((i >> b) & 1) == 1)
         begin : g_hit
            assign pick[i] = grant[i];
         end
         else
         begin : g_miss
            assign pick[i] = 1'b0;
         end
      end

      assign grant_id[b] = |pick;
   end

   // example with 8 requesters
   //   req          0100_0101
   //   prio_mask    1111_1000   last winner was requester 2
   //   masked_req   0100_0000
   //   sel_therm    1100_0000
   //   grant        0100_0000   grant_id = 6

endmodule

// ==== arbiter/rr_pointer.sv ====
/*
  registered priority mask for the round-robin arbiter
  moves only on ack with a nonzero grant; an ack with no winner is ignored
  mask bit is high for every requester strictly above the last acked winner
  resets to all ones, so requester 0 starts with top priority
*/
`timescale 1ns/10ps

module rr_pointer
#(
   parameter int num_req_p = 8
)
(
   input  logic                 clk_i,
   input  logic                 rst_n,
   input  logic [num_req_p-1:0] grant,
   input  logic                 ack,
   output logic [num_req_p-1:0] prio_mask
);

   localparam logic [num_req_p-1:0] one_lp = num_req_p'(1);

   // winner bit and every bit below it
   logic [num_req_p-1:0] at_or_below;

   // every bit strictly above the winner
   logic [num_req_p-1:0] above;

   logic [num_req_p-1:0] mask_next;

   // grant is one-hot here, so grant - 1 fills the bits below it
   assign at_or_below = grant | (grant - one_lp);
   assign above       = ~at_or_below;

   // top requester won, so nothing sits above it
   // open the whole vector and the search restarts at requester 0
   assign mask_next = (|above) ? above : '1;

   // pointer only moves when the current winner has been served
   always_ff @(posedge clk_i)
   begin
      if (!rst_n)
      begin
         prio_mask <= '1;
      end
      else if (ack && (|grant))
      begin
         prio_mask <= mask_next;
      end
   end

   // example with 8 requesters
   //   grant        0000_0100
   //   at_or_below  0000_0111
   //   mask_next    1111_1000
   // next search starts at requester 3

   // grant of 1000_0000 gives above = 0, so the mask goes back to all ones

endmodule

// ==== arbiter/rr_arbiter.sv ====
/*
  round-robin arbiter over num_req_p request levels
  grant, grant_valid and grant_id are combinational from req
  ack is a one-cycle pulse; the next winner is chosen past the acked one
  needs num_req_p of at least 2
*/
`timescale 1ns/10ps

module rr_arbiter
   import arb_pkg::*;
#(
   parameter int num_req_p = num_req_c
)
(
   input  logic                         clk_i,
   input  logic                         rst_n,
   input  logic [num_req_p-1:0]         req,
   input  logic                         ack,
   output logic [num_req_p-1:0]         grant,
   output logic                         grant_valid,
   output logic [$clog2(num_req_p)-1:0] grant_id
);

   // registered pointer, as a mask of requesters still ahead in this round
   logic [num_req_p-1:0] prio_mask;

   // the only state in the arbiter
   // samples the live grant on ack, so the mask moves one cycle later
   rr_pointer #(
      .num_req_p (num_req_p)
   ) u_pointer (
      .clk_i     (clk_i),
      .rst_n     (rst_n),
      .grant     (grant),
      .ack       (ack),
      .prio_mask (prio_mask)
   );

   // zero-cycle path from req to grant
   // uses the mask registered at the last rising edge
   rr_select #(
      .num_req_p (num_req_p)
   ) u_select (
      .req         (req),
      .prio_mask   (prio_mask),
      .grant       (grant),
      .grant_valid (grant_valid),
      .grant_id    (grant_id)
   );

   // while ack stays low the mask holds
   // the same requester keeps winning as long as req does not change

   // with no request, grant is zero, so an ack that cycle leaves the mask alone

endmodule

// ==== testbench/tb_clock.sv ====
/*
  free-running testbench clock, starts low at time zero
  period is set by period_p in ns
*/
`timescale 1ns/10ps

module tb_clock
#(
   parameter realtime period_p = 4.0
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
   end

   // toggle every half period
   always #(period_p / 2.0) clk = ~clk;

endmodule

// ==== testbench/rr_arbiter_checker.sv ====
/*
  concurrent checks on the arbiter grant outputs, bound into rr_arbiter
  sampled on the rising edge, quiet while reset is low
*/
`timescale 1ns/10ps

module rr_arbiter_checker
#(
   parameter int num_req_p = 8
)
(
   input logic                 clk_i,
   input logic                 rst_n,
   input logic [num_req_p-1:0] req,
   input logic [num_req_p-1:0] grant,
   input logic                 grant_valid
);

   // at most one winner per cycle
   a_grant_onehot : assert property (@(posedge clk_i) disable iff (!rst_n)
      $onehot0(grant))
      else $error("grant has more than one bit set");

   // only a requester can win
   a_grant_subset : assert property (@(posedge clk_i) disable iff (!rst_n)
      ((grant & ~req) == '0))
      else $error("grant set for a requester that is not requesting");

   // valid follows any request
   a_valid_any_req : assert property (@(posedge clk_i) disable iff (!rst_n)
      (grant_valid == (|req)))
      else $error("grant_valid does not match the OR of req");

endmodule

bind rr_arbiter rr_arbiter_checker #(
   .num_req_p (num_req_p)
) u_checker (
   .clk_i       (clk_i),
   .rst_n       (rst_n),
   .req         (req),
   .grant       (grant),
   .grant_valid (grant_valid)
);

// ==== testbench/tb_rr_arbiter.sv ====
/*
  testbench for rr_arbiter with the default requester count
  directed reset, back-pressure and idle-ack cases, then random cycles
  stops at the first mismatch
*/
`timescale 1ns/10ps

module tb_rr_arbiter
   import arb_pkg::*;
();

   localparam int num_req_lp    = num_req_c;
   localparam int rand_cycles_lp = 3000;
   localparam int reset_wait_lp  = 100;

   logic     clk_i;
   logic     rst_n;
   req_vec_t req;
   logic     ack;
   req_vec_t grant;
   logic     grant_valid;
   req_idx_t grant_id;

   // model state and random source
   int          model_last;
   logic [31:0] lfsr_state;
   int          error_count;

   tb_clock #(
      .period_p (4.0)
   ) u_clock (
      .clk (clk_i)
   );

   rr_arbiter #(
      .num_req_p (num_req_lp)
   ) dut (
      .clk_i       (clk_i),
      .rst_n       (rst_n),
      .req         (req),
      .ack         (ack),
      .grant       (grant),
      .grant_valid (grant_valid),
      .grant_id    (grant_id)
   );

   // galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic lsb;
      lsb = s[0];
      s = s >> 1;
      if (lsb)
      begin
         s = s ^ 32'h8020_0003;
      end
      return s;
   endfunction

   // one lfsr step per bit taken
   task automatic take_bit(output logic b);
      lfsr_state = lfsr_next(lfsr_state);
      b = lfsr_state[0];
   endtask

   // first active requester after last, wrapping, or -1 with no request
   function automatic int model_winner(input req_vec_t r, input int last);
      int idx;
      int found;
      found = -1;
      for (int k = 1; k <= num_req_lp; k++)
      begin
         idx = (last + k) % num_req_lp;
         if ((found < 0) && r[idx])
         begin
            found = idx;
         end
      end
      return found;
   endfunction

   task automatic report_failure();
      error_count++;
      $display("Finished with errors");
      $fatal(1, "stopped at the first error");
   endtask

   // compare all outputs with the model, hand back the expected winner
   task automatic check_outputs(output int winner);
      req_vec_t exp_grant;
      logic     exp_valid;
      req_idx_t exp_id;
      winner    = model_winner(req, model_last);
      exp_valid = (winner >= 0);
      exp_grant = '0;
      exp_id    = '0;
      if (exp_valid)
      begin
         exp_grant[winner] = 1'b1;
         exp_id = req_idx_t'(winner);
      end
      assert (grant_valid === exp_valid)
      else
      begin
         $display("mismatch grant_valid: got %h expected %h", grant_valid, exp_valid);
         report_failure();
      end
      assert (grant === exp_grant)
      else
      begin
         $display("mismatch grant: got %h expected %h", grant, exp_grant);
         report_failure();
      end
      // index must point at the single set grant bit
      if (exp_valid)
      begin
         assert (grant_id === exp_id)
         else
         begin
            $display("mismatch grant_id: got %h expected %h", grant_id, exp_id);
            report_failure();
         end
      end
   endtask

   // drive on the rising edge, check at the falling edge
   // model pointer moves with the edge that samples the ack
   task automatic run_cycle(input req_vec_t r, input logic a, output int winner);
      @(posedge clk_i);
      req <= r;
      ack <= a;
      @(negedge clk_i);
      check_outputs(winner);
      if (a && (winner >= 0))
      begin
         model_last = winner;
      end
   endtask

   task automatic wait_reset_release();
      int count;
      count = 0;
      while ((rst_n !== 1'b1) && (count < reset_wait_lp))
      begin
         @(posedge clk_i);
         count++;
      end
      if (rst_n !== 1'b1)
      begin
         $display("timeout while waiting for reset to be released");
         report_failure();
      end
   endtask

   // expected winner from a directed case, separate from the model
   task automatic expect_winner(input int got, input int want);
      assert (got == want)
      else
      begin
         $display("mismatch winner: got %h expected %h", got, want);
         report_failure();
      end
   endtask

   // reset for 10 cycles
   initial
   begin
      rst_n = 1'b0;
      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk_i);
      end
      rst_n <= 1'b1;
   end

   initial
   begin
      req_vec_t r;
      logic     a;
      logic     b;
      int       winner;
      req         = '0;
      ack         = 1'b0;
      error_count = 0;
      lfsr_state  = 32'h28e6;
      // reset mask is all ones, same as a last winner at the top
      model_last  = num_req_lp - 1;
      wait_reset_release();

      // lowest active requester wins after reset
      run_cycle(8'b0110_1100, 1'b0, winner);
      expect_winner(winner, 2);

      // ack low, winner holds
      for (int i = 0; i < 5; i++)
      begin
         run_cycle(8'b0110_1100, 1'b0, winner);
         expect_winner(winner, 2);
      end

      // ack walks the winner upward and wraps to the lowest
      run_cycle(8'b0110_1100, 1'b1, winner);
      run_cycle(8'b0110_1100, 1'b1, winner);
      expect_winner(winner, 3);
      run_cycle(8'b0110_1100, 1'b1, winner);
      expect_winner(winner, 5);
      run_cycle(8'b0110_1100, 1'b1, winner);
      expect_winner(winner, 6);
      // wrapped winner is acked too, so the mask now starts above 2
      run_cycle(8'b0110_1100, 1'b1, winner);
      expect_winner(winner, 2);

      // idle cycle with ack, next winner unchanged
      run_cycle('0, 1'b1, winner);
      expect_winner(winner, -1);
      run_cycle(8'b0110_1100, 1'b0, winner);
      expect_winner(winner, 3);

      // random requests, ack high about one cycle in four
      for (int c = 0; c < rand_cycles_lp; c++)
      begin
         for (int k = 0; k < num_req_lp; k++)
         begin
            take_bit(b);
            r[k] = b;
         end
         take_bit(a);
         take_bit(b);
         a = a & b;
         run_cycle(r, a, winner);
      end

      if (error_count == 0)
      begin
         $display("Finished with no errors");
      end
      else
      begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
common/arb_pkg.sv
logic/prefix_scan.sv
arbiter/rr_select.sv
arbiter/rr_pointer.sv
arbiter/rr_arbiter.sv
testbench/tb_clock.sv
testbench/rr_arbiter_checker.sv
testbench/tb_rr_arbiter.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the arbiter testbench with Verilator
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timing -Wno-fatal \
      --top-module tb_rr_arbiter -Mdir obj_dir -f vlog.f; then
   echo "build failed"
   exit 1
fi

if ! ./obj_dir/Vtb_rr_arbiter > sim.log 2>&1; then
   echo "simulation returned a failing status"
fi

cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
